/* src/cpuPkg.sv */
package cpuPkg;

  // Data path types
  typedef logic [31:0] wordT;      // Data, address and instruction word
  typedef logic [7:0]  opCodeT;
  typedef logic [3:0]  regIdxT;
  typedef logic [2:0]  flagsT;     // {greater, less, equal}, unsigned compare
  typedef logic [1:0]  mcStatusT;  // Memory controller answer

  // Memory controller status codes, held one cycle
  localparam mcStatusT mcIdle  = 2'd0;
  localparam mcStatusT mcReady = 2'd1;
  localparam mcStatusT mcError = 2'd2;

  // Register file layout
  localparam int     regCount        = 16;
  localparam regIdxT stackPointerReg = 4'd0;
  localparam regIdxT flagsReg        = 4'd1;
  localparam wordT   stackStep       = 32'd4;  // Bytes per stack slot

  // Opcodes, byte 0 of the instruction word
  localparam opCodeT MovRC  = 8'd1;   // 8-byte
  localparam opCodeT MovRR  = 8'd2;
  localparam opCodeT AddRRR = 8'd3;
  localparam opCodeT AddRRC = 8'd4;   // 8-byte
  localparam opCodeT SubRRR = 8'd5;
  localparam opCodeT SubRRC = 8'd6;   // 8-byte
  localparam opCodeT IncR   = 8'd7;
  localparam opCodeT DecR   = 8'd8;
  localparam opCodeT ShlRRR = 8'd9;
  localparam opCodeT ShrRRR = 8'd10;
  localparam opCodeT NegRR  = 8'd11;
  localparam opCodeT CmpRR  = 8'd12;
  localparam opCodeT CmpRC  = 8'd13;  // 8-byte
  localparam opCodeT JmpC   = 8'd14;  // 8-byte
  localparam opCodeT JeC    = 8'd15;  // 8-byte, taken on flag equal
  localparam opCodeT JneC   = 8'd16;  // 8-byte
  localparam opCodeT JzRC   = 8'd17;  // 8-byte, taken when rA is zero
  localparam opCodeT JnzRC  = 8'd18;  // 8-byte
  localparam opCodeT MovRdC = 8'd19;  // 8-byte load from constant address
  localparam opCodeT MovdCR = 8'd20;  // 8-byte store of rB to constant address
  localparam opCodeT PushR  = 8'd21;
  localparam opCodeT PopR   = 8'd22;
  localparam opCodeT CallR  = 8'd23;
  localparam opCodeT Ret    = 8'd24;

  localparam opCodeT maxOpCode = 8'd24;  // Zero and above this halt the core

  // Instruction cycle
  typedef enum logic [2:0] {
    fetch,        // Issue instruction read
    decode,       // Wait for instruction word
    readRegs,     // Register values settle, pick next step
    dataWord,     // Wait for the constant word
    memRequest,   // Issue data read or write
    memComplete,  // Wait for data access
    retire,       // Register writes and ip update
    errorHalt
  } cpuStateT;

  typedef enum logic [3:0] {
    none        = 4'd0,
    badInstr    = 4'd1,  // Error status on instruction fetch
    badDataWord = 4'd2,  // Error status on constant fetch
    badMem      = 4'd3,  // Error status on data access
    badOpCode   = 4'd4
  } errorCodeT;

endpackage

/* src/instrDecoder.sv */
`timescale 1ns/1ps

module instrDecoder (
  input  cpuPkg::wordT   instrWord,
  output cpuPkg::opCodeT opCode,
  output cpuPkg::regIdxT regA,
  output cpuPkg::regIdxT regB,
  output cpuPkg::regIdxT regC,
  output logic           hasDataWord,
  output logic           isLoad,
  output logic           isStore,
  output logic           opValid
);

  // Byte 0 is the opcode, bytes 1 to 3 carry register fields
  assign opCode = instrWord[7:0];
  assign regA   = instrWord[11:8];   // Low nibble of byte 1
  assign regB   = instrWord[19:16];  // Low nibble of byte 2
  assign regC   = instrWord[27:24];  // Low nibble of byte 3

  // Opcodes followed by a constant word
  assign hasDataWord = opCode inside {
    cpuPkg::MovRC,
    cpuPkg::AddRRC,
    cpuPkg::SubRRC,
    cpuPkg::CmpRC,
    cpuPkg::JmpC,
    cpuPkg::JeC,
    cpuPkg::JneC,
    cpuPkg::JzRC,
    cpuPkg::JnzRC,
    cpuPkg::MovRdC,
    cpuPkg::MovdCR
  };

  // Data reads, stack pops included
  assign isLoad = opCode inside {cpuPkg::MovRdC, cpuPkg::PopR, cpuPkg::Ret};

  // Data writes, call pushes its own ip
  assign isStore = opCode inside {cpuPkg::MovdCR, cpuPkg::PushR, cpuPkg::CallR};

  // Zero is never a legal opcode
  assign opValid = (opCode != 8'd0) && (opCode <= cpuPkg::maxOpCode);

endmodule

/* src/registerFile.sv */
`timescale 1ns/1ps

module registerFile (
  input  logic           clk,
  input  logic           reset,
  input  cpuPkg::regIdxT readIdxA,
  input  cpuPkg::regIdxT readIdxB,
  input  cpuPkg::regIdxT readIdxC,
  output cpuPkg::wordT   readDataA,
  output cpuPkg::wordT   readDataB,
  output cpuPkg::wordT   readDataC,
  output cpuPkg::wordT   stackPointer,
  output cpuPkg::wordT   flags,
  input  logic           writeEn,
  input  cpuPkg::regIdxT writeIdx,
  input  cpuPkg::wordT   writeData,
  input  logic           spWriteEn,
  input  cpuPkg::wordT   spWriteData,
  input  logic           flagsWriteEn,
  input  cpuPkg::flagsT  flagsData
);

  cpuPkg::wordT regs [cpuPkg::regCount];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < cpuPkg::regCount; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (writeEn) begin
        regs[writeIdx] <= writeData;
      end
      if (flagsWriteEn) begin
        regs[cpuPkg::flagsReg] <= cpuPkg::wordT'(flagsData);  // Upper bits cleared
      end
      // Written last, so a pop into r0 loses to the stack step
      if (spWriteEn) begin
        regs[cpuPkg::stackPointerReg] <= spWriteData;
      end
    end
  end

  // Combinational reads
  assign readDataA    = regs[readIdxA];
  assign readDataB    = regs[readIdxB];
  assign readDataC    = regs[readIdxC];
  assign stackPointer = regs[cpuPkg::stackPointerReg];
  assign flags        = regs[cpuPkg::flagsReg];

  // Compare result and a general write never target the flags register together
  flagsWriteExclusive: assert property (@(posedge clk) disable iff (reset)
    !(flagsWriteEn && writeEn && (writeIdx == cpuPkg::flagsReg)));

endmodule

/* src/executeUnit.sv */
`timescale 1ns/1ps

module executeUnit (
  input  cpuPkg::opCodeT opCode,
  input  cpuPkg::regIdxT regA,
  input  cpuPkg::wordT   valueA,
  input  cpuPkg::wordT   valueB,
  input  cpuPkg::wordT   valueC,
  input  cpuPkg::wordT   dataWord,
  input  cpuPkg::wordT   ramValue,
  input  cpuPkg::wordT   stackPointer,
  input  cpuPkg::wordT   flags,
  input  cpuPkg::wordT   ipointer,
  input  logic           hasDataWord,
  output logic           regWriteEn,
  output cpuPkg::regIdxT regWriteIdx,
  output cpuPkg::wordT   regWriteData,
  output logic           spWriteEn,
  output cpuPkg::wordT   spWriteData,
  output logic           flagsWriteEn,
  output cpuPkg::flagsT  flagsData,
  output cpuPkg::wordT   memAddress,
  output cpuPkg::wordT   memWriteData,
  output cpuPkg::wordT   nextIpointer
);

  cpuPkg::wordT spUp;
  cpuPkg::wordT spDown;
  cpuPkg::wordT seqIpointer;
  cpuPkg::wordT cmpRhs;
  logic         condTaken;

  assign spUp        = stackPointer + cpuPkg::stackStep;  // Push and call
  assign spDown      = stackPointer - cpuPkg::stackStep;  // Pop and return
  assign seqIpointer = ipointer + (hasDataWord ? 32'd8 : 32'd4);
  assign cmpRhs      = (opCode == cpuPkg::CmpRC) ? dataWord : valueB;

  // Branch condition, flags bit 0 is equal
  always_comb begin
    case (opCode)
      cpuPkg::JeC:   condTaken = flags[0];
      cpuPkg::JneC:  condTaken = !flags[0];
      cpuPkg::JzRC:  condTaken = (valueA == '0);
      cpuPkg::JnzRC: condTaken = (valueA != '0);
      default:       condTaken = 1'b0;
    endcase
  end

  always_comb begin
    // Defaults suit the plain ALU ops and the constant address store
    regWriteEn   = 1'b0;
    regWriteIdx  = regA;  // Destination is always field A
    regWriteData = '0;
    spWriteEn    = 1'b0;
    spWriteData  = spUp;
    flagsWriteEn = 1'b0;
    flagsData    = {valueA > cmpRhs, valueA < cmpRhs, valueA == cmpRhs};
    memAddress   = dataWord;
    memWriteData = valueB;    // MovdCR stores rB
    nextIpointer = condTaken ? dataWord : seqIpointer;

    case (opCode)
      cpuPkg::MovRC:  {regWriteEn, regWriteData} = {1'b1, dataWord};
      cpuPkg::MovRR:  {regWriteEn, regWriteData} = {1'b1, valueB};
      cpuPkg::AddRRR: {regWriteEn, regWriteData} = {1'b1, valueB + valueC};
      cpuPkg::AddRRC: {regWriteEn, regWriteData} = {1'b1, valueB + dataWord};
      cpuPkg::SubRRR: {regWriteEn, regWriteData} = {1'b1, valueB - valueC};
      cpuPkg::SubRRC: {regWriteEn, regWriteData} = {1'b1, valueB - dataWord};
      cpuPkg::IncR:   {regWriteEn, regWriteData} = {1'b1, valueA + 32'd1};
      cpuPkg::DecR:   {regWriteEn, regWriteData} = {1'b1, valueA - 32'd1};
      cpuPkg::ShlRRR: {regWriteEn, regWriteData} = {1'b1, valueB << valueC};
      cpuPkg::ShrRRR: {regWriteEn, regWriteData} = {1'b1, valueB >> valueC};  // Logical
      cpuPkg::NegRR:  {regWriteEn, regWriteData} = {1'b1, -valueB};
      cpuPkg::CmpRR,
      cpuPkg::CmpRC:  flagsWriteEn = 1'b1;
      cpuPkg::JmpC:   nextIpointer = dataWord;
      cpuPkg::MovRdC: {regWriteEn, regWriteData} = {1'b1, ramValue};
      cpuPkg::PushR: begin
        memAddress   = stackPointer;  // Write at sp, then step up
        memWriteData = valueA;
        spWriteEn    = 1'b1;
      end
      cpuPkg::PopR: begin
        memAddress   = spDown;
        regWriteEn   = 1'b1;
        regWriteData = ramValue;
        spWriteEn    = 1'b1;
        spWriteData  = spDown;
      end
      cpuPkg::CallR: begin
        memAddress   = stackPointer;
        memWriteData = ipointer;      // Own ip, return adds 4
        spWriteEn    = 1'b1;
        nextIpointer = valueA;
      end
      cpuPkg::Ret: begin
        memAddress   = spDown;
        spWriteEn    = 1'b1;
        spWriteData  = spDown;
        nextIpointer = ramValue + 32'd4;  // Skip the call itself
      end
      default: begin
      end
    endcase
  end

endmodule

/* src/cpuControl.sv */
`timescale 1ns/1ps

module cpuControl (
  input  logic              clk,
  input  logic              reset,
  output logic              readReq,
  output logic              writeReq,
  output cpuPkg::wordT      ramAddress,
  output cpuPkg::wordT      ramOut,
  input  cpuPkg::wordT      ramIn,
  input  cpuPkg::mcStatusT  mcStatus,
  output cpuPkg::wordT      instrWord,
  output cpuPkg::wordT      dataWord,
  output cpuPkg::wordT      ramValue,
  output cpuPkg::wordT      ipointer,
  input  logic              hasDataWord,
  input  logic              isLoad,
  input  logic              isStore,
  input  logic              opValid,
  input  cpuPkg::wordT      memAddress,
  input  cpuPkg::wordT      memWriteData,
  input  cpuPkg::wordT      nextIpointer,
  output logic              retireEn,
  output logic              halted,
  output cpuPkg::errorCodeT errorCode
);

  cpuPkg::cpuStateT state;
  logic             reqPending;   // Request sent, no status yet
  logic             statusReady;
  logic             statusError;

  assign statusReady = (mcStatus == cpuPkg::mcReady);
  assign statusError = (mcStatus == cpuPkg::mcError);
  assign retireEn    = (state == cpuPkg::retire) && opValid;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state     <= cpuPkg::fetch;
      readReq   <= 1'b0;
      writeReq  <= 1'b0;
      ipointer  <= '0;
      halted    <= 1'b0;
      errorCode <= cpuPkg::none;
    end else begin
      readReq  <= 1'b0;  // Single-cycle pulses
      writeReq <= 1'b0;
      case (state)
        cpuPkg::fetch: begin
          readReq <= 1'b1;
          state   <= cpuPkg::decode;
        end
        cpuPkg::decode: begin
          if (statusReady) begin
            state <= cpuPkg::readRegs;
          end else if (statusError) begin
            halted    <= 1'b1;
            errorCode <= cpuPkg::badInstr;
            state     <= cpuPkg::errorHalt;
          end
        end
        cpuPkg::readRegs: begin
          if (hasDataWord) begin
            readReq <= 1'b1;  // Constant sits right after the opcode word
            state   <= cpuPkg::dataWord;
          end else if (isLoad || isStore) begin
            state <= cpuPkg::memRequest;
          end else begin
            state <= cpuPkg::retire;
          end
        end
        cpuPkg::dataWord: begin
          if (statusReady) begin
            state <= (isLoad || isStore) ? cpuPkg::memRequest : cpuPkg::retire;
          end else if (statusError) begin
            halted    <= 1'b1;
            errorCode <= cpuPkg::badDataWord;
            state     <= cpuPkg::errorHalt;
          end
        end
        cpuPkg::memRequest: begin
          readReq  <= isLoad;
          writeReq <= isStore;
          state    <= cpuPkg::memComplete;
        end
        cpuPkg::memComplete: begin
          if (statusReady) begin
            state <= cpuPkg::retire;
          end else if (statusError) begin
            halted    <= 1'b1;
            errorCode <= cpuPkg::badMem;
            state     <= cpuPkg::errorHalt;
          end
        end
        cpuPkg::retire: begin
          if (opValid) begin
            ipointer <= nextIpointer;
            state    <= cpuPkg::fetch;
          end else begin
            // ip left on the bad instruction
            halted    <= 1'b1;
            errorCode <= cpuPkg::badOpCode;
            state     <= cpuPkg::errorHalt;
          end
        end
        default: begin
          state <= cpuPkg::errorHalt;  // Stuck until reset
        end
      endcase
    end
  end

  // Address, write data and captured responses
  always_ff @(posedge clk) begin
    case (state)
      cpuPkg::fetch: begin
        ramAddress <= ipointer;
      end
      cpuPkg::decode: begin
        if (statusReady) begin
          instrWord <= ramIn;
        end
      end
      cpuPkg::readRegs: begin
        ramAddress <= ipointer + 32'd4;
      end
      cpuPkg::dataWord: begin
        if (statusReady) begin
          dataWord <= ramIn;
        end
      end
      cpuPkg::memRequest: begin
        ramAddress <= memAddress;
        ramOut     <= memWriteData;
      end
      cpuPkg::memComplete: begin
        if (statusReady) begin
          ramValue <= ramIn;  // Unused by stores
        end
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      reqPending <= 1'b0;
    end else if (statusReady || statusError) begin
      reqPending <= 1'b0;
    end else if (readReq || writeReq) begin
      reqPending <= 1'b1;
    end
  end

  reqExclusive: assert property (@(posedge clk) disable iff (reset)
    !(readReq && writeReq));

  // Next request only once the controller has answered
  oneOutstanding: assert property (@(posedge clk) disable iff (reset)
    (readReq || writeReq) |-> !reqPending);

endmodule

/* src/cpuCore.sv */
`timescale 1ns/1ps

module cpuCore (
  input  logic              clk,
  input  logic              reset,
  output logic              readReq,
  output logic              writeReq,
  output cpuPkg::wordT      ramAddress,
  output cpuPkg::wordT      ramOut,
  input  cpuPkg::wordT      ramIn,
  input  cpuPkg::mcStatusT  mcStatus,
  output cpuPkg::wordT      ipointer,
  output logic              halted,
  output cpuPkg::errorCodeT errorCode
);

  // Decoded fields
  cpuPkg::wordT   instrWord;
  cpuPkg::opCodeT opCode;
  cpuPkg::regIdxT regA, regB, regC;
  logic           hasDataWord, isLoad, isStore, opValid;

  // Operands and captured memory words
  cpuPkg::wordT   valueA, valueB, valueC;
  cpuPkg::wordT   dataWord, ramValue, stackPointer, flags;

  // Execute results
  logic           regWriteEn, spWriteEn, flagsWriteEn, retireEn;
  cpuPkg::regIdxT regWriteIdx;
  cpuPkg::wordT   regWriteData, spWriteData;
  cpuPkg::flagsT  flagsData;
  cpuPkg::wordT   memAddress, memWriteData, nextIpointer;

  instrDecoder decoder0 (.*);

  // Writes land only on the retire edge
  registerFile regFile0 (
    .*,
    .readIdxA(regA),
    .readIdxB(regB),
    .readIdxC(regC),
    .readDataA(valueA),
    .readDataB(valueB),
    .readDataC(valueC),
    .writeEn(regWriteEn && retireEn),
    .writeIdx(regWriteIdx),
    .writeData(regWriteData),
    .spWriteEn(spWriteEn && retireEn),
    .flagsWriteEn(flagsWriteEn && retireEn)
  );

  executeUnit exec0 (.*);

  cpuControl control0 (.*);

endmodule

/* sim/cpuChecker.sv */
`timescale 1ns/1ps

module cpuChecker (
  input  logic              clk,
  input  logic              reset,
  input  logic              readReq,
  input  logic              writeReq,
  input  cpuPkg::wordT      ramAddress,
  input  cpuPkg::wordT      ramOut,
  input  logic              halted,
  input  cpuPkg::wordT      ipointer,
  input  cpuPkg::errorCodeT errorCode,
  input  cpuPkg::wordT      prog [256],
  input  logic              errMode,   // First data store answered with error
  input  logic              checkNow,
  output int                passCount,
  output int                failCount
);

  cpuPkg::wordT      gotAddr[$], gotData[$], expAddr[$], expData[$];
  cpuPkg::wordT      expIp;
  cpuPkg::errorCodeT expErr;
  int                lateReqs;   // Requests seen after halt

  function automatic cpuPkg::wordT cmpFlags(cpuPkg::wordT x, cpuPkg::wordT y);
    return {29'd0, x > y, x < y, x == y};
  endfunction

  // ISA model, run over the program image
  task automatic runModel();
    cpuPkg::wordT r [16];
    cpuPkg::wordT m [256];
    cpuPkg::wordT ip, w, k, nxt, t;
    int           a, b, c;
    bit           done;
    m = prog;
    r = '{default: '0};
    ip = '0;
    done = 0;
    expErr = cpuPkg::none;
    expAddr = {};
    expData = {};
    for (int step = 0; step < 5000 && !done; step++) begin
      w = m[ip[9:2]];
      k = m[ip[9:2] + 8'd1];  // Constant word
      a = int'(w[11:8]);
      b = int'(w[19:16]);
      c = int'(w[27:24]);
      nxt = ip + 32'd4;
      case (w[7:0])
        8'd1:  begin r[a] = k; nxt = ip + 32'd8; end
        8'd2:  r[a] = r[b];
        8'd3:  r[a] = r[b] + r[c];
        8'd4:  begin r[a] = r[b] + k; nxt = ip + 32'd8; end
        8'd5:  r[a] = r[b] - r[c];
        8'd6:  begin r[a] = r[b] - k; nxt = ip + 32'd8; end
        8'd7:  r[a] = r[a] + 32'd1;
        8'd8:  r[a] = r[a] - 32'd1;
        8'd9:  r[a] = r[b] << r[c];
        8'd10: r[a] = r[b] >> r[c];
        8'd11: r[a] = -r[b];
        8'd12: r[1] = cmpFlags(r[a], r[b]);
        8'd13: begin r[1] = cmpFlags(r[a], k); nxt = ip + 32'd8; end
        8'd14: nxt = k;
        8'd15: nxt = r[1][0] ? k : ip + 32'd8;
        8'd16: nxt = !r[1][0] ? k : ip + 32'd8;
        8'd17: nxt = (r[a] == '0) ? k : ip + 32'd8;
        8'd18: nxt = (r[a] != '0) ? k : ip + 32'd8;
        8'd19: begin r[a] = m[k[9:2]]; nxt = ip + 32'd8; end
        8'd20, 8'd21, 8'd23: begin
          t = r[a];
          if (w[7:0] == 8'd20) begin
            expAddr.push_back(k);
            expData.push_back(r[b]);
          end else begin
            expAddr.push_back(r[0]);
            expData.push_back((w[7:0] == 8'd21) ? r[a] : ip);  // Call pushes own ip
          end
          if (errMode) begin
            expErr = cpuPkg::badMem;  // ip stays on the store
            done = 1;
          end else begin
            m[expAddr[$][9:2]] = expData[$];
            if (w[7:0] == 8'd20) begin
              nxt = ip + 32'd8;
            end else begin
              r[0] = r[0] + 32'd4;
            end
            if (w[7:0] == 8'd23) nxt = t;
          end
        end
        8'd22: begin
          t = r[0] - 32'd4;
          r[a] = m[t[9:2]];
          r[0] = t;  // Stack step wins over pop into r0
        end
        8'd24: begin
          r[0] = r[0] - 32'd4;
          nxt = m[r[0][9:2]] + 32'd4;
        end
        default: begin
          expErr = cpuPkg::badOpCode;
          done = 1;
        end
      endcase
      if (!done) ip = nxt;
    end
    expIp = ip;
    if (!done) begin
      $display("Model did not reach a halt");
      expErr = cpuPkg::none;
    end
  endtask

  task automatic compare();
    string name;
    int    errs;
    name = errMode ? "memError" : "randomProgram";
    errs = 0;
    runModel();
    if (gotAddr.size() != expAddr.size()) begin
      $display("[ERROR] %s write count expected %0d actual %0d",
               name, expAddr.size(), gotAddr.size());
      errs++;
    end
    for (int i = 0; i < expAddr.size() && i < gotAddr.size(); i++) begin
      if (gotAddr[i] != expAddr[i] || gotData[i] != expData[i]) begin
        $display("[ERROR] %s write %0d expected %h@%h actual %h@%h",
                 name, i, expData[i], expAddr[i], gotData[i], gotAddr[i]);
        errs++;
      end
    end
    if (ipointer != expIp) begin
      $display("[ERROR] %s ipointer expected %h actual %h", name, expIp, ipointer);
      errs++;
    end
    if (errorCode != expErr) begin
      $display("[ERROR] %s errorCode expected %0d actual %0d", name, expErr, errorCode);
      errs++;
    end
    if (lateReqs != 0) begin
      $display("%s: core issued %0d requests after halting", name, lateReqs);
      errs++;
    end
    $display("%s: %s, %0d writes checked", name, (errs == 0) ? "passed" : "failed",
             gotAddr.size());
    if (errs == 0) passCount++;
    else failCount++;
  endtask

  initial begin
    passCount = 0;
    failCount = 0;
  end

  // Bus watch, registered outputs sampled on the edge
  always @(posedge clk) begin
    if (reset) begin
      gotAddr = {};
      gotData = {};
      lateReqs = 0;
    end else begin
      if (writeReq) begin
        gotAddr.push_back(ramAddress);
        gotData.push_back(ramOut);
      end
      if (halted && (readReq || writeReq)) lateReqs++;
      if (checkNow) compare();
    end
  end

endmodule

/* sim/cpuTb.sv */
`timescale 1ns/1ps

module cpuTb;

  logic              clk, reset;
  logic              readReq, writeReq, halted;
  cpuPkg::wordT      ramAddress, ramOut, ramIn, ipointer;
  cpuPkg::mcStatusT  mcStatus;
  cpuPkg::errorCodeT errorCode;
  cpuPkg::wordT      prog [256];   // Program image, 1 KB
  cpuPkg::wordT      mem [256];    // Live memory
  logic              errMode, checkNow;
  int                seed, pc, passCount, failCount, timeouts;

  cpuCore dut0 (.*);
  cpuChecker chk0 (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic int rnd(int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  task automatic put(cpuPkg::opCodeT op, int a, int b, int c);
    prog[pc] = {4'h0, c[3:0], 4'h0, b[3:0], 4'h0, a[3:0], op};
    pc++;
  endtask

  task automatic putK(cpuPkg::opCodeT op, int a, int b, cpuPkg::wordT k);
    put(op, a, b, 0);
    prog[pc] = k;
    pc++;
  endtask

  task automatic genProgram();
    int op, skip, ra;
    for (int i = 0; i < 256; i++) prog[i] = 32'hc0de0000 | (i << 2);  // Address fill
    pc = 0;
    putK(cpuPkg::MovRC, 0, 0, 32'h280);  // Stack pointer
    for (int r = 2; r < 10; r++) putK(cpuPkg::MovRC, r, 0, $random(seed));
    for (int n = 0; n < 12; n++) begin
      op = 2 + rnd(10);
      if (op == 4 || op == 6) putK(cpuPkg::opCodeT'(op), 2 + rnd(14), rnd(16), $random(seed));
      else put(cpuPkg::opCodeT'(op), 2 + rnd(14), rnd(16), rnd(16));
    end
    for (int n = 0; n < 4; n++) begin
      op = 15 + rnd(4);  // JeC to JnzRC
      skip = rnd(2);
      ra = 2 + rnd(8);
      if (op < 17) put(cpuPkg::CmpRR, ra, rnd(2) ? ra : 2 + rnd(8), 0);  // Equal half the time
      putK(cpuPkg::opCodeT'(op), 2 + rnd(8), 0, cpuPkg::wordT'(pc * 4 + 8 + skip * 4));
      put(cpuPkg::IncR, 3, 0, 0);  // Skipped when target is past it
    end
    put(cpuPkg::PushR, 2, 0, 0);
    put(cpuPkg::PushR, 3, 0, 0);
    put(cpuPkg::PopR, 4, 0, 0);
    put(cpuPkg::PopR, 5, 0, 0);
    putK(cpuPkg::MovRC, 15, 0, cpuPkg::wordT'(pc * 4 + 20));  // Subroutine address
    put(cpuPkg::CallR, 15, 0, 0);
    putK(cpuPkg::JmpC, 0, 0, cpuPkg::wordT'(pc * 4 + 16));    // Over the subroutine
    put(cpuPkg::IncR, 2, 0, 0);
    put(cpuPkg::Ret, 0, 0, 0);
    putK(cpuPkg::MovdCR, 0, 6, 32'h3c0);
    putK(cpuPkg::MovRdC, 7, 0, 32'h3c0);
    for (int r = 0; r < 16; r++) putK(cpuPkg::MovdCR, 0, r, cpuPkg::wordT'(32'h300 + r * 4));
    prog[pc] = '0;  // Bad opcode ends the run
  endtask

  // Memory controller, 0 to 5 cycles late
  initial begin
    cpuPkg::wordT addr, data;
    logic         isWrite;
    int           delay;
    forever begin
      @(posedge clk);
      #1 mcStatus = cpuPkg::mcIdle;
      if (!reset && (readReq || writeReq)) begin
        addr = ramAddress;
        data = ramOut;
        isWrite = writeReq;
        delay = rnd(6);
        for (int i = 0; i < delay; i++) @(posedge clk);
        if (delay > 0) #1;
        if (isWrite && errMode) begin
          mcStatus = cpuPkg::mcError;
        end else begin
          mcStatus = cpuPkg::mcReady;
          if (isWrite) mem[addr[9:2]] = data;
          ramIn = mem[addr[9:2]];
        end
      end
    end
  end

  task automatic runTest(logic withError);
    int cycles;
    errMode = withError;
    mem = prog;
    reset = 1'b1;
    repeat (4) @(posedge clk);
    #1 reset = 1'b0;
    cycles = 0;
    while (!halted && cycles < 20000) begin
      @(posedge clk);
      cycles++;
    end
    if (!halted) begin
      $display("timed out waiting for halt");
      timeouts++;
    end else begin
      repeat (10) @(posedge clk);  // Window for stray requests
      #1 checkNow = 1'b1;
      @(posedge clk);
      #1 checkNow = 1'b0;
    end
  endtask

  initial begin
    seed = 32'hfbf;
    reset = 1'b1;
    ramIn = '0;
    mcStatus = cpuPkg::mcIdle;
    errMode = 1'b0;
    checkNow = 1'b0;
    timeouts = 0;
    genProgram();
    runTest(1'b0);
    runTest(1'b1);
    $display("tests passed %0d failed %0d", passCount, failCount + timeouts);
    if (failCount == 0 && timeouts == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* src.f */
src/cpuPkg.sv
src/instrDecoder.sv
src/registerFile.sv
src/executeUnit.sv
src/cpuControl.sv
src/cpuCore.sv
sim/cpuChecker.sv
sim/cpuTb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module cpuTb -o cpuSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/cpuSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "RESULT: FAIL" sim.log; then
  exit 1
fi
exit 0
